//--- Bender.yml
package:
  name: motion_ctrl

sources:
  - design/motion_pkg.sv
  - design/spi_cmd_pkg.sv
  - design/input_sync.sv
  - design/spi_frame_rx.sv
  - design/quad_decoder.sv
  - design/step_counter.sv
  - design/cmd_decoder.sv
  - design/motion_ctrl_top.sv
  - target: test
    files:
      - test/motion_ctrl_asserts.sv
      - test/motion_ctrl_tb.sv

//--- all.f
design/motion_pkg.sv
design/spi_cmd_pkg.sv
design/input_sync.sv
design/spi_frame_rx.sv
design/quad_decoder.sv
design/step_counter.sv
design/cmd_decoder.sv
design/motion_ctrl_top.sv
test/motion_ctrl_asserts.sv
test/motion_ctrl_tb.sv

//--- design/cmd_decoder.sv
// command decoder holding the configuration registers and selecting the SPI reply word
`timescale 1ns/1ps

module cmd_decoder (
  input  logic                    clk,
  input  logic                    resetn,
  input  spi_cmd_pkg::spi_frame_t frame,
  input  logic                    req,
  output logic                    ack,
  output spi_cmd_pkg::resp_t      resp,
  input  motion_pkg::count_t      quad_count,
  input  motion_pkg::count_t      step_count,
  input  logic                    fault,
  output motion_pkg::mult_t       quad_mult,
  output motion_pkg::mult_t       step_mult,
  output logic                    app_resetn,
  output logic [7:0]              leds
);

  import motion_pkg::*;
  import spi_cmd_pkg::*;

  // one execution per request, on its first cycle
  logic exec;

  assign exec = req & ~ack;

  // ack side of the handshake
  // rises one cycle after req, falls once req has dropped
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      ack <= 1'b0;
    end
    else if (exec)
    begin
      ack <= 1'b1;
    end
    else if (!req && ack)
    begin
      ack <= 1'b0;
    end
  end

  // register writes and reply selection
  // writes and app control keep the previous reply
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      resp       <= RESP_DEFAULT;
      quad_mult  <= QUAD_MULT_RST;
      step_mult  <= STEP_MULT_RST;
      app_resetn <= 1'b1;
      leds       <= 8'h00;
    end
    else if (exec)
    begin
      case (frame.opcode)
        OP_RD_STEP:      resp <= resp_t'(step_count);
        OP_RD_QUAD:      resp <= resp_t'(quad_count);
        OP_ECHO:         resp <= frame.arg;
        OP_WR_QUAD_MULT: quad_mult <= frame.arg[7:0];
        OP_WR_STEP_MULT: step_mult <= frame.arg[7:0];
        OP_RD_QUAD_MULT: resp <= {24'h000000, quad_mult};
        OP_RD_STEP_MULT: resp <= {24'h000000, step_mult};
        // hold clears counts and fault but not the multipliers
        OP_APP_HOLD:     app_resetn <= 1'b0;
        OP_APP_RUN:      app_resetn <= 1'b1;
        OP_WR_LED:       leds <= frame.arg[7:0];
        OP_RD_APP:       resp <= {31'h00000000, app_resetn};
        OP_RD_FAULT:     resp <= {31'h00000000, fault};
        default:         resp <= RESP_DEFAULT;
      endcase
    end
  end

endmodule

//--- design/input_sync.sv
// two-stage synchronizer for a group of asynchronous pins, instantiated per pin group in the top
`timescale 1ns/1ps

module input_sync #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic resetn,
  input  T     d,
  output T     q
);

  // first stage, may go metastable
  T meta;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      meta <= '0;
      q    <= '0;
    end
    else
    begin
      // whole group moves together
      meta <= d;
      q    <= meta;
    end
  end

endmodule

//--- design/motion_ctrl_top.sv
// top level of the SPI motion-feedback controller, wires pin synchronizers, receiver, counters and decoder
`timescale 1ns/1ps

module motion_ctrl_top (
  input  logic                   clk,
  input  logic                   resetn,
  input  motion_pkg::enc_pins_t  enc,
  input  motion_pkg::step_pins_t step_pins,
  input  spi_cmd_pkg::spi_pins_t spi_in,
  output logic                   miso,
  output logic [7:0]             leds,
  output logic                   faultn,
  output logic                   app_running
);

  import motion_pkg::*;
  import spi_cmd_pkg::*;

  // synchronized pin groups
  enc_pins_t  enc_s;
  step_pins_t step_s;
  spi_pins_t  spi_s;

  // receiver to decoder handshake
  spi_frame_t frame;
  logic       req;
  logic       ack;
  resp_t      resp;

  // counter data and control
  count_t quad_count;
  count_t step_count;
  mult_t  quad_mult;
  mult_t  step_mult;
  logic   fault;
  logic   app_resetn;
  logic   cnt_resetn;

  // counters clear on system reset or while the application is held
  assign cnt_resetn = resetn & app_resetn;

  assign faultn      = ~fault;
  assign app_running = app_resetn;

  input_sync #(.T(enc_pins_t)) enc_sync (
    .clk    (clk),
    .resetn (resetn),
    .d      (enc),
    .q      (enc_s)
  );

  input_sync #(.T(step_pins_t)) step_sync (
    .clk    (clk),
    .resetn (resetn),
    .d      (step_pins),
    .q      (step_s)
  );

  input_sync #(.T(spi_pins_t)) spi_sync (
    .clk    (clk),
    .resetn (resetn),
    .d      (spi_in),
    .q      (spi_s)
  );

  spi_frame_rx u_spi_frame_rx (
    .clk    (clk),
    .resetn (resetn),
    .pins   (spi_s),
    .resp   (resp),
    .miso   (miso),
    .frame  (frame),
    .req    (req),
    .ack    (ack)
  );

  quad_decoder u_quad_decoder (
    .clk        (clk),
    .app_resetn (cnt_resetn),
    .ab         (enc_s),
    .mult       (quad_mult),
    .count      (quad_count),
    .fault      (fault)
  );

  step_counter u_step_counter (
    .clk        (clk),
    .app_resetn (cnt_resetn),
    .pins       (step_s),
    .mult       (step_mult),
    .count      (step_count)
  );

  cmd_decoder u_cmd_decoder (
    .clk        (clk),
    .resetn     (resetn),
    .frame      (frame),
    .req        (req),
    .ack        (ack),
    .resp       (resp),
    .quad_count (quad_count),
    .step_count (step_count),
    .fault      (fault),
    .quad_mult  (quad_mult),
    .step_mult  (step_mult),
    .app_resetn (app_resetn),
    .leds       (leds)
  );

endmodule

//--- design/motion_pkg.sv
// motion types shared by the encoder and step counters, the command decoder and the testbench
package motion_pkg;

  // signed position count, wraps at 32 bits
  typedef logic signed [31:0] count_t;

  // per-event scale factor, unsigned
  typedef logic [7:0] mult_t;

  // multiplier values after system reset
  localparam mult_t QUAD_MULT_RST = 8'd4;
  localparam mult_t STEP_MULT_RST = 8'd5;

  // quadrature encoder channels
  typedef struct packed {
    logic a;
    logic b;
  } enc_pins_t;

  // step/direction input pair
  // dir high counts up
  typedef struct packed {
    logic step;
    logic dir;
  } step_pins_t;

endpackage

//--- design/quad_decoder.sv
// quadrature encoder decoder with scaled up/down count and sticky illegal-transition fault
`timescale 1ns/1ps

module quad_decoder (
  input  logic                  clk,
  input  logic                  app_resetn,
  input  motion_pkg::enc_pins_t ab,
  input  motion_pkg::mult_t     mult,
  output motion_pkg::count_t    count,
  output logic                  fault
);

  import motion_pkg::*;

  // current and previous encoder state
  enc_pins_t cur_ab;
  enc_pins_t prev_ab;

  // which channels changed between the two states
  logic [1:0] diff;
  logic       one_step;
  logic       both_flip;
  logic       up;

  // multiplier widened to the count type, zero extended
  count_t delta;

  assign diff      = cur_ab ^ prev_ab;
  assign one_step  = ^diff;
  assign both_flip = &diff;

  // forward order 00 -> 10 -> 11 -> 01 -> 00 with {a,b}
  // for a single-bit change the direction is prev.b xor cur.a
  assign up = prev_ab.b ^ cur_ab.a;

  assign delta = count_t'(mult);

  // state tracker
  // in hold both stages follow the pins, so release gives no false step
  always_ff @(posedge clk)
  begin
    if (!app_resetn)
    begin
      cur_ab  <= ab;
      prev_ab <= ab;
    end
    else
    begin
      cur_ab  <= ab;
      prev_ab <= cur_ab;
    end
  end

  // scaled position count
  always_ff @(posedge clk)
  begin
    if (!app_resetn)
    begin
      count <= '0;
    end
    else if (one_step)
    begin
      if (up)
      begin
        count <= count + delta;
      end
      else
      begin
        count <= count - delta;
      end
    end
  end

  // both channels moved in one sample, count is no longer trusted
  // stays set until the application is held in reset
  always_ff @(posedge clk)
  begin
    if (!app_resetn)
    begin
      fault <= 1'b0;
    end
    else if (both_flip)
    begin
      fault <= 1'b1;
    end
  end

endmodule

//--- design/spi_cmd_pkg.sv
// SPI command set, frame layout and reply word used by the receiver, decoder and testbench
package spi_cmd_pkg;

  // bits per frame, opcode byte then 32-bit argument
  localparam int FRAME_BITS = 40;

  // bit counter wide enough to hold FRAME_BITS
  localparam int FRAME_CNT_W = $clog2(FRAME_BITS + 1);

  // host opcodes
  typedef enum logic [7:0] {
    OP_RD_STEP      = 8'd1,
    OP_RD_QUAD      = 8'd2,
    OP_ECHO         = 8'd3,
    OP_WR_QUAD_MULT = 8'd4,
    OP_WR_STEP_MULT = 8'd5,
    OP_RD_QUAD_MULT = 8'd6,
    OP_RD_STEP_MULT = 8'd7,
    OP_APP_HOLD     = 8'd8,
    OP_APP_RUN      = 8'd9,
    OP_WR_LED       = 8'd10,
    OP_RD_APP       = 8'd14,
    OP_RD_FAULT     = 8'd15
  } opcode_t;

  // one received frame, opcode in the upper byte
  typedef struct packed {
    opcode_t     opcode;
    logic [31:0] arg;
  } spi_frame_t;

  // reply word shifted out during the next frame
  typedef logic [31:0] resp_t;

  // reply for opcodes that are not recognized
  localparam resp_t RESP_DEFAULT = 32'd1234567890;

  // raw SPI slave pins
  typedef struct packed {
    logic sck;
    logic ssel;
    logic mosi;
  } spi_pins_t;

endpackage

//--- design/spi_frame_rx.sv
// SPI mode 0 slave that assembles 40-bit frames, shifts replies out and hands frames to the decoder
`timescale 1ns/1ps

module spi_frame_rx (
  input  logic                   clk,
  input  logic                   resetn,
  input  spi_cmd_pkg::spi_pins_t  pins,
  input  spi_cmd_pkg::resp_t      resp,
  output logic                   miso,
  output spi_cmd_pkg::spi_frame_t frame,
  output logic                   req,
  input  logic                   ack
);

  import spi_cmd_pkg::*;

  // previous synchronized sck and ssel for edge detection
  logic sck_d;
  logic ssel_d;

  logic sck_rise;
  logic sck_fall;
  logic ssel_fall;
  logic ssel_rise;

  // receive shift register and bit count for the current frame
  logic [FRAME_BITS-1:0]  shift_in;
  logic [FRAME_CNT_W-1:0] bit_cnt;

  // reply shift register, MSB on miso
  resp_t shift_out;

  // pins are already synchronized, one more flop gives the edges
  assign sck_rise  = pins.sck & ~sck_d;
  assign sck_fall  = ~pins.sck & sck_d;
  assign ssel_fall = ~pins.ssel & ssel_d;
  assign ssel_rise = pins.ssel & ~ssel_d;

  assign miso = shift_out[31];

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      sck_d  <= 1'b0;
      ssel_d <= 1'b0;
    end
    else
    begin
      sck_d  <= pins.sck;
      ssel_d <= pins.ssel;
    end
  end

  // mosi capture, only while selected
  always_ff @(posedge clk)
  begin
    if (sck_rise && !pins.ssel)
    begin
      shift_in <= {shift_in[FRAME_BITS-2:0], pins.mosi};
    end
  end

  // bit count, cleared at the start of each frame and held at its top value
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      bit_cnt <= '0;
    end
    else if (ssel_fall)
    begin
      bit_cnt <= '0;
    end
    else if (sck_rise && !pins.ssel && (bit_cnt != '1))
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // reply is taken when the host selects us, then sent MSB first
  // zeros follow once all 32 bits are out
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      shift_out <= '0;
    end
    else if (ssel_fall)
    begin
      shift_out <= resp;
    end
    else if (sck_fall && !pins.ssel)
    begin
      shift_out <= {shift_out[30:0], 1'b0};
    end
  end

  // frame hand-off, req side of the four-phase handshake
  // a frame of the wrong length or one arriving mid-handshake is dropped
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      req <= 1'b0;
    end
    else if (req)
    begin
      if (ack)
      begin
        req <= 1'b0;
      end
    end
    else if (ssel_rise && !ack && (bit_cnt == FRAME_CNT_W'(FRAME_BITS)))
    begin
      req <= 1'b1;
    end
  end

  // frame only changes while no request is outstanding
  always_ff @(posedge clk)
  begin
    if (!req && ssel_rise && !ack && (bit_cnt == FRAME_CNT_W'(FRAME_BITS)))
    begin
      frame <= spi_frame_t'(shift_in);
    end
  end

endmodule

//--- design/step_counter.sv
// step/direction position counter that adds or subtracts the step multiplier per step pulse
`timescale 1ns/1ps

module step_counter (
  input  logic                   clk,
  input  logic                   app_resetn,
  input  motion_pkg::step_pins_t pins,
  input  motion_pkg::mult_t      mult,
  output motion_pkg::count_t     count
);

  import motion_pkg::*;

  // two delayed copies of the pin pair, newest first
  step_pins_t pins_d1;
  step_pins_t pins_d2;

  logic   step_rise;
  count_t delta;

  // step pulse starts on the low to high edge
  assign step_rise = pins_d1.step & ~pins_d2.step;

  // zero extended, multiplier is never negative
  assign delta = count_t'(mult);

  // edge register
  // held equal in reset so leaving hold does not count a step
  always_ff @(posedge clk)
  begin
    if (!app_resetn)
    begin
      pins_d1 <= pins;
      pins_d2 <= pins;
    end
    else
    begin
      pins_d1 <= pins;
      pins_d2 <= pins_d1;
    end
  end

  // dir sampled together with the step edge
  always_ff @(posedge clk)
  begin
    if (!app_resetn)
    begin
      count <= '0;
    end
    else if (step_rise)
    begin
      if (pins_d1.dir)
      begin
        count <= count + delta;
      end
      else
      begin
        count <= count - delta;
      end
    end
  end

endmodule

//--- test/motion_ctrl_asserts.sv
// handshake checks bound into the SPI frame receiver, compiled with the testbench
`timescale 1ns/1ps

module motion_ctrl_asserts (
  input logic                    clk,
  input logic                    resetn,
  input logic                    req,
  input logic                    ack,
  input spi_cmd_pkg::spi_frame_t frame
);

  // number of assertion failures so far
  int fail_count = 0;

  // request stays up until the decoder answers
  req_held_until_ack: assert property (
    @(posedge clk) disable iff (!resetn)
    (req && !ack) |=> req
  ) else
  begin
    $error("req dropped before ack was seen");
    fail_count++;
  end

  // decoder reads the frame while req is up, so it must not move
  frame_stable_in_req: assert property (
    @(posedge clk) disable iff (!resetn)
    req |=> (!req || $stable(frame))
  ) else
  begin
    $error("frame changed while req was high");
    fail_count++;
  end

  // ack may only fall once req is already low
  ack_falls_after_req: assert property (
    @(posedge clk) disable iff (!resetn)
    $fell(ack) |-> !$past(req)
  ) else
  begin
    $error("ack fell while req was still high");
    fail_count++;
  end

endmodule

// one checker per receiver instance
bind spi_frame_rx motion_ctrl_asserts u_motion_ctrl_asserts (
  .clk    (clk),
  .resetn (resetn),
  .req    (req),
  .ack    (ack),
  .frame  (frame)
);

//--- test/motion_ctrl_tb.sv
// directed testbench for the SPI motion controller, simulation top that drives SPI and sensor pins
`timescale 1ns/1ps

module motion_ctrl_tb;

  import motion_pkg::*;
  import spi_cmd_pkg::*;

  localparam int CLK_PERIOD = 8;
  // sck runs at clk/8, so half a bit is 4 clocks
  localparam int SCK_HALF = 4;
  // clocks between two sensor pin changes
  localparam int PIN_GAP = 6;
  // clocks allowed for each handshake phase
  localparam int HS_TIMEOUT = 16;
  // upper bound on frames sent over the whole run
  localparam int NUM_FRAMES = 48;
  // frames x bits x clocks per bit x period, plus 20 percent
  localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_BITS * 8 * CLK_PERIOD * 12 / 10;

  logic       clk;
  logic       resetn;
  enc_pins_t  enc;
  step_pins_t step_pins;
  spi_pins_t  spi_in;
  logic       miso;
  logic [7:0] leds;
  logic       faultn;
  logic       app_running;

  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          assert_fails;
  logic [31:0] rng_state;

  // model of what the DUT should hold
  mult_t  quad_mult_exp;
  mult_t  step_mult_exp;
  count_t quad_exp;
  count_t step_exp;

  motion_ctrl_top u_motion_ctrl_top (
    .clk         (clk),
    .resetn      (resetn),
    .enc         (enc),
    .step_pins   (step_pins),
    .spi_in      (spi_in),
    .miso        (miso),
    .leds        (leds),
    .faultn      (faultn),
    .app_running (app_running)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // xorshift32, state kept between calls
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_leds(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // new failures of the bound handshake checker count as errors
  task automatic collect_assert_fails();
    int total;
    total = u_motion_ctrl_top.u_spi_frame_rx.u_motion_ctrl_asserts.fail_count;
    if (total != assert_fails)
    begin
      $display("%0d handshake assertion failure(s)", total - assert_fails);
      errors += total - assert_fails;
      assert_fails = total;
    end
  endtask

  // one SPI mode 0 frame, MSB first, starting and ending on a falling clk edge
  // nbits below FRAME_BITS cuts the frame short
  task automatic spi_xfer(input logic [7:0] op, input logic [31:0] arg, input int nbits,
                          output resp_t rx);
    logic [FRAME_BITS-1:0] bits;
    int                    waited;
    bits = {op, arg};
    rx = '0;
    spi_in.ssel = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      spi_in.mosi = bits[FRAME_BITS-1-i];
      repeat (SCK_HALF) @(negedge clk);
      // host samples miso just before the rising edge
      if (i < 32)
      begin
        rx[31-i] = miso;
      end
      spi_in.sck = 1'b1;
      repeat (SCK_HALF) @(negedge clk);
      spi_in.sck = 1'b0;
    end
    repeat (SCK_HALF) @(negedge clk);
    spi_in.ssel = 1'b1;
    spi_in.mosi = 1'b0;
    if (nbits == FRAME_BITS)
    begin
      // full frame, follow the receiver/decoder handshake to its end
      waited = 0;
      while (!u_motion_ctrl_top.req && waited < HS_TIMEOUT)
      begin
        @(negedge clk);
        waited++;
      end
      if (!u_motion_ctrl_top.req)
      begin
        $display("no request raised after a full frame, opcode 0x%02h", op);
        errors++;
      end
      waited = 0;
      while ((u_motion_ctrl_top.req || u_motion_ctrl_top.ack) && waited < HS_TIMEOUT)
      begin
        @(negedge clk);
        waited++;
      end
      if (u_motion_ctrl_top.req || u_motion_ctrl_top.ack)
      begin
        $display("handshake did not close after opcode 0x%02h", op);
        errors++;
      end
    end
    else
    begin
      // a short frame must never raise req
      for (int i = 0; i < HS_TIMEOUT; i++)
      begin
        @(negedge clk);
        if (u_motion_ctrl_top.req)
        begin
          $display("a frame of %0d bits raised a request", nbits);
          errors++;
        end
      end
    end
    // ssel high time between frames
    repeat (SCK_HALF) @(negedge clk);
  endtask

  task automatic send_cmd(input logic [7:0] op, input logic [31:0] arg);
    resp_t unused;
    spi_xfer(op, arg, FRAME_BITS, unused);
  endtask

  // reply arrives during the following frame, a dummy echo
  task automatic read_reply(input logic [7:0] op, input logic [31:0] arg, output resp_t rx);
    send_cmd(op, arg);
    spi_xfer(OP_ECHO, next_rand(), FRAME_BITS, rx);
  endtask

  // forward order with {a,b} is 00 10 11 01
  task automatic quad_move(input bit fwd);
    enc_pins_t nxt;
    if (fwd)
    begin
      nxt.a = ~enc.b;
      nxt.b = enc.a;
    end
    else
    begin
      nxt.a = enc.b;
      nxt.b = ~enc.a;
    end
    enc = nxt;
    repeat (PIN_GAP) @(negedge clk);
  endtask

  // dir settles before the step edge
  task automatic step_pulse(input bit fwd);
    step_pins.dir = fwd;
    repeat (PIN_GAP) @(negedge clk);
    step_pins.step = 1'b1;
    repeat (PIN_GAP) @(negedge clk);
    step_pins.step = 1'b0;
    repeat (PIN_GAP) @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    collect_assert_fails();
    if (errors == errors_before)
    begin
      $display("test %s: ok", name);
      tests_passed++;
    end
    else
    begin
      $display("test %s: %0d error(s)", name, errors - errors_before);
      tests_failed++;
    end
  endtask

  task automatic test_reset_values();
    resp_t rx;
    read_reply(OP_RD_QUAD_MULT, 32'h0, rx);
    check_resp("quad_mult", rx, {24'h000000, QUAD_MULT_RST});
    read_reply(OP_RD_STEP_MULT, 32'h0, rx);
    check_resp("step_mult", rx, {24'h000000, STEP_MULT_RST});
    read_reply(OP_RD_APP, 32'h0, rx);
    check_resp("app_state", rx, 32'd1);
    check_flag("faultn", faultn, 1'b1);
    check_leds("leds", leds, 8'h00);
    // opcode outside the command set
    read_reply(8'hff, 32'h0, rx);
    check_resp("unknown_reply", rx, 32'd1234567890);
  endtask

  task automatic test_echo_and_mults();
    resp_t       rx;
    logic [31:0] arg;
    arg = next_rand();
    read_reply(OP_ECHO, arg, rx);
    check_resp("echo", rx, arg);
    // keep the multipliers nonzero so the count tests see movement
    arg = next_rand();
    arg[0] = (arg[7:0] == 8'h00) ? 1'b1 : arg[0];
    send_cmd(OP_WR_QUAD_MULT, arg);
    quad_mult_exp = arg[7:0];
    read_reply(OP_RD_QUAD_MULT, 32'h0, rx);
    check_resp("quad_mult", rx, {24'h000000, quad_mult_exp});
    arg = next_rand();
    arg[0] = (arg[7:0] == 8'h00) ? 1'b1 : arg[0];
    send_cmd(OP_WR_STEP_MULT, arg);
    step_mult_exp = arg[7:0];
    read_reply(OP_RD_STEP_MULT, 32'h0, rx);
    check_resp("step_mult", rx, {24'h000000, step_mult_exp});
  endtask

  task automatic test_step_count();
    resp_t rx;
    int    n;
    int    m;
    n = 2 + int'(next_rand() % 5);
    m = 2 + int'(next_rand() % 6);
    for (int i = 0; i < n; i++)
    begin
      step_pulse(1'b1);
    end
    for (int i = 0; i < m; i++)
    begin
      step_pulse(1'b0);
    end
    step_exp = step_exp + count_t'((n - m) * int'(step_mult_exp));
    read_reply(OP_RD_STEP, 32'h0, rx);
    check_count("step_count", count_t'(rx), step_exp);
  endtask

  task automatic test_quad_count();
    resp_t rx;
    int    f;
    int    r;
    f = 4 + int'(next_rand() % 8);
    r = 2 + int'(next_rand() % 8);
    for (int i = 0; i < f; i++)
    begin
      quad_move(1'b1);
    end
    for (int i = 0; i < r; i++)
    begin
      quad_move(1'b0);
    end
    quad_exp = quad_exp + count_t'((f - r) * int'(quad_mult_exp));
    read_reply(OP_RD_QUAD, 32'h0, rx);
    check_count("quad_count", count_t'(rx), quad_exp);
  endtask

  task automatic test_fault_and_hold();
    resp_t     rx;
    enc_pins_t nxt;
    int        waited;
    // both channels at once is an illegal transition
    nxt.a = ~enc.a;
    nxt.b = ~enc.b;
    enc = nxt;
    waited = 0;
    while (faultn && waited < HS_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    check_flag("faultn", faultn, 1'b0);
    repeat (PIN_GAP) @(negedge clk);
    read_reply(OP_RD_FAULT, 32'h0, rx);
    check_resp("fault", rx, 32'd1);
    send_cmd(OP_APP_HOLD, 32'h0);
    check_flag("app_running", app_running, 1'b0);
    read_reply(OP_RD_APP, 32'h0, rx);
    check_resp("app_state", rx, 32'd0);
    send_cmd(OP_APP_RUN, 32'h0);
    check_flag("app_running", app_running, 1'b1);
    check_flag("faultn", faultn, 1'b1);
    // hold clears counts and fault only
    quad_exp = '0;
    step_exp = '0;
    read_reply(OP_RD_FAULT, 32'h0, rx);
    check_resp("fault", rx, 32'd0);
    read_reply(OP_RD_QUAD, 32'h0, rx);
    check_count("quad_count", count_t'(rx), quad_exp);
    read_reply(OP_RD_STEP, 32'h0, rx);
    check_count("step_count", count_t'(rx), step_exp);
    read_reply(OP_RD_QUAD_MULT, 32'h0, rx);
    check_resp("quad_mult", rx, {24'h000000, quad_mult_exp});
    read_reply(OP_RD_STEP_MULT, 32'h0, rx);
    check_resp("step_mult", rx, {24'h000000, step_mult_exp});
  endtask

  task automatic test_leds_and_short();
    resp_t       rx;
    logic [31:0] led_arg;
    logic [31:0] echo_arg;
    led_arg = next_rand();
    send_cmd(OP_WR_LED, led_arg);
    check_leds("leds", leds, led_arg[7:0]);
    echo_arg = next_rand();
    send_cmd(OP_ECHO, echo_arg);
    // cut short at 20 bits, must be dropped
    spi_xfer(OP_WR_LED, ~led_arg, 20, rx);
    check_leds("leds", leds, led_arg[7:0]);
    spi_xfer(OP_ECHO, next_rand(), FRAME_BITS, rx);
    check_resp("echo_after_short", rx, echo_arg);
  endtask

  initial
  begin
    int err_start;
    resetn = 1'b0;
    enc = '0;
    step_pins = '0;
    spi_in.sck = 1'b0;
    spi_in.ssel = 1'b1;
    spi_in.mosi = 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    assert_fails = 0;
    rng_state = 32'hdf1fd2b8;
    quad_mult_exp = QUAD_MULT_RST;
    step_mult_exp = STEP_MULT_RST;
    quad_exp = '0;
    step_exp = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    repeat (4) @(negedge clk);

    err_start = errors;
    test_reset_values();
    finish_test("reset_values", err_start);
    err_start = errors;
    test_echo_and_mults();
    finish_test("echo_and_mults", err_start);
    err_start = errors;
    test_step_count();
    finish_test("step_count", err_start);
    err_start = errors;
    test_quad_count();
    finish_test("quad_count", err_start);
    err_start = errors;
    test_fault_and_hold();
    finish_test("fault_and_hold", err_start);
    err_start = errors;
    test_leds_and_short();
    finish_test("leds_and_short", err_start);

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog sized from the frame budget
  initial
  begin
    #(WATCHDOG_NS);
    $display("run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failures found");
    $finish;
  end

endmodule
